// ==== design/pow5_pkg.sv ====
// Arithmetic path constants and types: word width, data word, pipeline depth, operand range
`default_nettype none

package pow5_pkg;

    // ------------------------------
    // Word format
    // ------------------------------

    // Operands and results share one width, products wrap modulo 2**12
    localparam int data_width = 12;

    typedef logic [data_width - 1:0] data_t;

    // ------------------------------
    // Pipeline and operand range
    // ------------------------------

    // Square, fourth power, fifth power
    localparam int pipe_stages = 3;

    // Operand counter runs 0 .. max_operand
    localparam int max_operand = 5;

endpackage

`default_nettype wire

// ==== design/display_pkg.sv ====
// Display definitions: digit count, segment type, hex decode table, blank pattern
`default_nettype none

package display_pkg;

    // Four digit multiplexed display
    localparam int num_digits = 4;

    // Segment order a b c d e f g h, h is the dot and sits in bit 0
    typedef logic [7:0] seg_t;

    // ------------------------------
    // Hex decode, active high
    // ------------------------------

    localparam seg_t hex_segments [16] = '{
        8'hFC, 8'h60, 8'hDA, 8'hF2,   // 0 1 2 3
        8'h66, 8'hB6, 8'hBE, 8'hE0,   // 4 5 6 7
        8'hFE, 8'hF6, 8'hEE, 8'h3E,   // 8 9 A b
        8'h9C, 8'h7A, 8'h9E, 8'h8E    // C d E F
    };

    // All segments dark
    localparam seg_t seg_blank = 8'h00;

endpackage

`default_nettype wire

// ==== design/display_feed_if.sv ====
// Display feed interface: operand, FIFO head and handshake status for the scanner
`timescale 1ns/1ps
`default_nettype none

interface display_feed_if import pow5_pkg::*; ();

    data_t operand;
    data_t result;
    logic  up_rdy;
    logic  down_vld;

    // Input side owns the operand
    modport operand_src (
        output operand
    );

    // Processing side owns the head word and the handshake status
    modport status_src (
        output result,
        output up_rdy,
        output down_vld
    );

    // Display side only looks
    modport sink (
        input operand,
        input result,
        input up_rdy,
        input down_vld
    );

endinterface

`default_nettype wire

// ==== design/operand_counter.sv ====
// Input side: wrapping operand counter stepped by accepted upstream transfers
`timescale 1ns/1ps
`default_nettype none

module operand_counter import pow5_pkg::*; (
    input  logic                       slow_clk,
    input  logic                       rst,
    input  logic                       up_vld,
    input  logic                       up_rdy,
    display_feed_if.operand_src        feed
);

    localparam int cnt_width = $clog2(max_operand + 1);

    logic [cnt_width - 1:0] cnt_q;
    logic                   up_xfer;

    assign up_xfer = up_vld & up_rdy;

    // Step only on a real transfer so the offered word stays stable
    always_ff @(posedge slow_clk or posedge rst) begin
        if (rst) begin
            cnt_q <= '0;
        end else if (up_xfer) begin
            if (cnt_q == cnt_width'(max_operand)) begin
                cnt_q <= '0;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    assign feed.operand = data_t'(cnt_q);

endmodule

`default_nettype wire

// ==== design/pow5_pipeline.sv ====
// Three stage x**5 pipeline with per-stage valid bits, products truncated to the word width
`timescale 1ns/1ps
`default_nettype none

module pow5_pipeline import pow5_pkg::*; (
    input  logic  slow_clk,
    input  logic  rst,
    input  logic  in_vld,
    input  data_t in_data,
    output logic  out_vld,
    output data_t out_data
);

    // Valid bit per stage, index 0 is the first stage
    logic [pipe_stages - 1:0] vld_q;

    data_t s1_sq;
    data_t s1_x;
    data_t s2_p4;
    data_t s2_x;
    data_t s3_p5;

    // ------------------------------
    // Valid tracking
    // ------------------------------

    // No stall path, back-pressure lives in the credit counter
    always_ff @(posedge slow_clk or posedge rst) begin
        if (rst) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[pipe_stages - 2:0], in_vld};
        end
    end

    // ------------------------------
    // Datapath
    // ------------------------------

    // Stage 1: x**2
    always_ff @(posedge slow_clk) begin
        if (in_vld) begin
            s1_sq <= in_data * in_data;
            s1_x  <= in_data;
        end
    end

    // Stage 2: x**4, operand rides along
    always_ff @(posedge slow_clk) begin
        if (vld_q[0]) begin
            s2_p4 <= s1_sq * s1_sq;
            s2_x  <= s1_x;
        end
    end

    // Stage 3: x**5
    always_ff @(posedge slow_clk) begin
        if (vld_q[1]) begin
            s3_p5 <= s2_p4 * s2_x;
        end
    end

    assign out_vld  = vld_q[pipe_stages - 1];
    assign out_data = s3_p5;

endmodule

`default_nettype wire

// ==== design/result_fifo.sv ====
// Result FIFO: circular buffer with occupancy count and combinational head word
`timescale 1ns/1ps
`default_nettype none

module result_fifo import pow5_pkg::*; #(
    parameter int fifo_depth = 4
) (
    input  logic  slow_clk,
    input  logic  rst,
    input  logic  wr_en,
    input  data_t wr_data,
    input  logic  rd_en,
    output data_t rd_data,
    output logic  not_empty
);

    localparam int ptr_width = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int cnt_width = $clog2(fifo_depth + 1);

    data_t                  mem [fifo_depth];
    logic [ptr_width - 1:0] wr_ptr_q;
    logic [ptr_width - 1:0] rd_ptr_q;
    logic [cnt_width - 1:0] count_q;
    logic                   full;
    logic                   wr_fire;
    logic                   rd_fire;

    assign full      = count_q == cnt_width'(fifo_depth);
    assign not_empty = count_q != '0;
    assign wr_fire   = wr_en & ~full;
    assign rd_fire   = rd_en & not_empty;

    // Storage
    always_ff @(posedge slow_clk) begin
        if (wr_fire) begin
            mem[wr_ptr_q] <= wr_data;
        end
    end

    // ------------------------------
    // Pointers and occupancy
    // ------------------------------

    // Explicit wrap so a depth that is not a power of two works too
    always_ff @(posedge slow_clk or posedge rst) begin
        if (rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr_q <= (wr_ptr_q == ptr_width'(fifo_depth - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr_q <= (rd_ptr_q == ptr_width'(fifo_depth - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (wr_fire & ~rd_fire) begin
                count_q <= count_q + 1'b1;
            end else if (rd_fire & ~wr_fire) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // Head word, valid whenever not_empty is high
    assign rd_data = mem[rd_ptr_q];

endmodule

`default_nettype wire

// ==== design/pow5_credit_unit.sv ====
// Processing side: credit counter around the x**5 pipeline and the result FIFO
`timescale 1ns/1ps
`default_nettype none

module pow5_credit_unit import pow5_pkg::*; #(
    parameter int fifo_depth = 4
) (
    input  logic                slow_clk,
    input  logic                rst,
    input  logic                up_vld,
    input  data_t               up_data,
    input  logic                down_rdy,
    output data_t               down_data,
    display_feed_if.status_src  feed
);

    localparam int credit_width = $clog2(fifo_depth + 1);

    logic [credit_width - 1:0] credit_q;
    logic [credit_width - 1:0] credit_d;
    logic                      up_rdy_q;
    logic                      up_xfer;
    logic                      down_xfer;
    logic                      pipe_vld;
    data_t                     pipe_data;
    data_t                     head;
    logic                      not_empty;

    assign up_xfer   = up_vld & up_rdy_q;
    assign down_xfer = not_empty & down_rdy;

    // ------------------------------
    // Credits
    // ------------------------------

    // One credit per FIFO slot, taken at entry and returned at exit
    always_comb begin
        credit_d = credit_q;
        if (up_xfer & ~down_xfer) begin
            credit_d = credit_q - 1'b1;
        end else if (down_xfer & ~up_xfer) begin
            credit_d = credit_q + 1'b1;
        end
    end

    // Ready is registered from the next count, so it never lags the credits
    always_ff @(posedge slow_clk or posedge rst) begin
        if (rst) begin
            credit_q <= credit_width'(fifo_depth);
            up_rdy_q <= 1'b1;
        end else begin
            credit_q <= credit_d;
            up_rdy_q <= credit_d != '0;
        end
    end

    pow5_pipeline pow5_pipeline_i (
        .slow_clk (slow_clk),
        .rst      (rst),
        .in_vld   (up_xfer),
        .in_data  (up_data),
        .out_vld  (pipe_vld),
        .out_data (pipe_data)
    );

    result_fifo #(.fifo_depth(fifo_depth)) result_fifo_i (
        .slow_clk  (slow_clk),
        .rst       (rst),
        .wr_en     (pipe_vld),
        .wr_data   (pipe_data),
        .rd_en     (down_xfer),
        .rd_data   (head),
        .not_empty (not_empty)
    );

    assign down_data     = head;
    assign feed.result   = head;
    assign feed.up_rdy   = up_rdy_q;
    assign feed.down_vld = not_empty;

endmodule

`default_nettype wire

// ==== design/segment_scanner.sv ====
// Display side: digit scan, hex to segment decode and blanking of idle handshake sides
`timescale 1ns/1ps
`default_nettype none

module segment_scanner import display_pkg::*; #(
    parameter int refresh_cycles = 4
) (
    input  logic                      slow_clk,
    input  logic                      rst,
    display_feed_if.sink              feed,
    output seg_t                      abcdefgh,
    output logic [num_digits - 1:0]   digit
);

    localparam int refresh_width = (refresh_cycles > 1) ? $clog2(refresh_cycles) : 1;

    logic [refresh_width - 1:0] refresh_q;
    logic [num_digits - 1:0]    digit_q;
    logic                       step;
    logic [4 * num_digits - 1:0] nibbles;
    logic [3:0]                 nibble;
    logic                       blank;

    // ------------------------------
    // Scan timing
    // ------------------------------

    assign step = refresh_q == refresh_width'(refresh_cycles - 1);

    // Rightmost digit first, then one place left per refresh period
    always_ff @(posedge slow_clk or posedge rst) begin
        if (rst) begin
            refresh_q <= '0;
            digit_q   <= num_digits'(1);
        end else if (step) begin
            refresh_q <= '0;
            digit_q   <= {digit_q[num_digits - 2:0], digit_q[num_digits - 1]};
        end else begin
            refresh_q <= refresh_q + 1'b1;
        end
    end

    // ------------------------------
    // Digit contents
    // ------------------------------

    // Left digit is the operand, the rest the FIFO head
    assign nibbles = {feed.operand[3:0], feed.result[11:0]};

    always_comb begin
        nibble = '0;
        for (int i = 0; i < num_digits; i++) begin
            if (digit_q[i]) begin
                nibble = nibbles[4 * i +: 4];
            end
        end
    end

    // Dark when the matching side has nothing to offer
    assign blank = (digit_q[num_digits - 1] & ~feed.up_rdy)
                 | ((|digit_q[num_digits - 2:0]) & ~feed.down_vld);

    assign abcdefgh = blank ? seg_blank : hex_segments[nibble];
    assign digit    = digit_q;

endmodule

`default_nettype wire

// ==== design/pow5_board_top.sv ====
// Board top: keys to handshakes, operand counter, credit unit, display scanner and LEDs
`timescale 1ns/1ps
`default_nettype none

module pow5_board_top import pow5_pkg::*; import display_pkg::*; #(
    parameter int fifo_depth     = 4,
    parameter int refresh_cycles = 4
) (
    input  logic                    slow_clk,
    input  logic                    rst,
    input  logic [1:0]              key,
    output data_t                   up_data,
    output logic                    up_rdy,
    output logic                    down_vld,
    output data_t                   down_data,
    output seg_t                    abcdefgh,
    output logic [num_digits - 1:0] digit,
    output logic [3:0]              led
);

    logic up_vld;
    logic down_rdy;

    // Key 1 offers an operand, key 0 takes a result
    assign up_vld   = key[1];
    assign down_rdy = key[0];

    display_feed_if feed ();

    operand_counter operand_counter_i (
        .slow_clk (slow_clk),
        .rst      (rst),
        .up_vld   (up_vld),
        .up_rdy   (feed.up_rdy),
        .feed     (feed)
    );

    pow5_credit_unit #(.fifo_depth(fifo_depth)) pow5_credit_unit_i (
        .slow_clk  (slow_clk),
        .rst       (rst),
        .up_vld    (up_vld),
        .up_data   (feed.operand),
        .down_rdy  (down_rdy),
        .down_data (down_data),
        .feed      (feed)
    );

    segment_scanner #(.refresh_cycles(refresh_cycles)) segment_scanner_i (
        .slow_clk (slow_clk),
        .rst      (rst),
        .feed     (feed),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

    // ------------------------------
    // Handshake pins and LEDs
    // ------------------------------

    assign up_data  = feed.operand;
    assign up_rdy   = feed.up_rdy;
    assign down_vld = feed.down_vld;
    assign led      = {up_vld, feed.up_rdy, feed.down_vld, down_rdy};

endmodule

`default_nettype wire

// ==== testbench/tb_pow5_board.sv ====
// Testbench for the board top: clock, reset, LFSR key stimulus, reference model, assertions
`timescale 1ns/1ps
`default_nettype none

module tb_pow5_board import pow5_pkg::*; import display_pkg::*; ();

    localparam int fifo_depth     = 4;
    localparam int refresh_cycles = 4;
    localparam int drain_timeout  = 100;

    logic                    slow_clk;
    logic                    rst;
    logic [1:0]              key;
    data_t                   up_data;
    logic                    up_rdy;
    logic                    down_vld;
    data_t                   down_data;
    seg_t                    abcdefgh;
    logic [num_digits - 1:0] digit;
    logic [3:0]              led;

    // Reference model state
    data_t model_q [$];
    int    accept_q [$];
    int    model_count;
    data_t model_front;
    int    front_cycle;
    data_t model_operand;
    int    cycle_cnt;
    logic  drained;
    seg_t  exp_seg;
    logic [3:0] exp_led;
    logic [num_digits - 1:0] exp_digit;

    logic [31:0] lfsr;
    logic        up_key;
    logic        down_key;
    int          wait_cnt;

    pow5_board_top #(
        .fifo_depth     (fifo_depth),
        .refresh_cycles (refresh_cycles)
    ) pow5_board_top_i (
        .slow_clk  (slow_clk),
        .rst       (rst),
        .key       (key),
        .up_data   (up_data),
        .up_rdy    (up_rdy),
        .down_vld  (down_vld),
        .down_data (down_data),
        .abcdefgh  (abcdefgh),
        .digit     (digit),
        .led       (led)
    );

    // ------------------------------
    // Helpers
    // ------------------------------

    // Taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // x**5 with every product wrapped to 12 bits
    function automatic data_t fifth_power(input data_t x);
        data_t acc;
        acc = 12'd1;
        for (int i = 0; i < 5; i++) begin
            acc = acc * x;
        end
        return acc;
    endfunction

    function automatic data_t next_operand(input data_t op);
        return (op == data_t'(max_operand)) ? 12'd0 : op + 12'd1;
    endfunction

    // Left digit shows the operand, the other three the result nibbles
    function automatic seg_t expected_segments(input logic [3:0] sel, input data_t operand,
                                               input data_t result, input logic rdy,
                                               input logic vld);
        logic [3:0] nib;
        logic       dark;
        nib  = 4'h0;
        dark = 1'b0;
        if (sel[3]) begin
            nib  = operand[3:0];
            dark = !rdy;
        end else if (sel[2]) begin
            nib  = result[11:8];
            dark = !vld;
        end else if (sel[1]) begin
            nib  = result[7:4];
            dark = !vld;
        end else begin
            nib  = result[3:0];
            dark = !vld;
        end
        return dark ? seg_blank : hex_segments[nib];
    endfunction

    task automatic report_mismatch(input string test_name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("error: %s expected %0h actual %0h", test_name, expected, actual);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    assign exp_seg = expected_segments(digit, up_data, down_data, up_rdy, down_vld);
    assign exp_led = {key[1], up_rdy, down_vld, key[0]};

    // Rightmost digit first, one place left per refresh period
    assign exp_digit = num_digits'(1) << ((cycle_cnt / refresh_cycles) % num_digits);

    // ------------------------------
    // Reference model
    // ------------------------------

    always @(posedge slow_clk or posedge rst) begin
        if (rst) begin
            model_q.delete();
            accept_q.delete();
            model_count   <= 0;
            model_front   <= '0;
            front_cycle   <= 0;
            model_operand <= '0;
            cycle_cnt     <= 0;
        end else begin
            if (down_vld && key[0] && model_q.size() != 0) begin
                void'(model_q.pop_front());
                void'(accept_q.pop_front());
            end
            if (key[1] && up_rdy) begin
                model_q.push_back(fifth_power(up_data));
                accept_q.push_back(cycle_cnt);
                model_operand <= next_operand(model_operand);
            end
            cycle_cnt   <= cycle_cnt + 1;
            model_count <= model_q.size();
            if (model_q.size() != 0) begin
                model_front <= model_q[0];
                front_cycle <= accept_q[0];
            end
        end
    end

    // ------------------------------
    // Assertions
    // ------------------------------

    reset_state: assert property (@(posedge slow_clk) disable iff (rst)
        (cycle_cnt == 0) |-> (up_rdy && !down_vld && up_data == '0 && digit == 4'b0001))
        else report_failure("outputs after reset are not in the idle state");

    operand_step: assert property (@(posedge slow_clk) disable iff (rst)
        up_data == model_operand)
        else report_mismatch("operand_step", 32'($sampled(model_operand)),
                             32'($sampled(up_data)));

    result_source: assert property (@(posedge slow_clk) disable iff (rst)
        (down_vld && key[0]) |-> (model_count != 0))
        else report_failure("a result left the FIFO with no operand outstanding");

    result_order: assert property (@(posedge slow_clk) disable iff (rst)
        (down_vld && key[0] && model_count != 0) |-> (down_data == model_front))
        else report_mismatch("result_order", 32'($sampled(model_front)),
                             32'($sampled(down_data)));

    result_latency: assert property (@(posedge slow_clk) disable iff (rst)
        (down_vld && key[0] && model_count != 0) |->
            (cycle_cnt - front_cycle >= pipe_stages + 1))
        else report_failure("a result left the FIFO before the pipeline latency");

    credit_bound: assert property (@(posedge slow_clk) disable iff (rst)
        model_count <= fifo_depth)
        else report_failure("more operands outstanding than FIFO slots");

    ready_rule: assert property (@(posedge slow_clk) disable iff (rst)
        up_rdy == (model_count != fifo_depth))
        else report_mismatch("ready_rule", 32'($sampled(model_count) != fifo_depth),
                             32'($sampled(up_rdy)));

    drain_empty: assert property (@(posedge slow_clk) disable iff (rst)
        drained |-> (model_count == 0 && !down_vld))
        else report_failure("results are missing after the FIFO ran empty");

    digit_scan: assert property (@(posedge slow_clk) disable iff (rst)
        digit == exp_digit)
        else report_mismatch("digit_scan", 32'($sampled(exp_digit)), 32'($sampled(digit)));

    segment_decode: assert property (@(posedge slow_clk) disable iff (rst)
        abcdefgh == exp_seg)
        else report_mismatch("segment_decode", 32'($sampled(exp_seg)),
                             32'($sampled(abcdefgh)));

    led_mirror: assert property (@(posedge slow_clk) disable iff (rst)
        led == exp_led)
        else report_mismatch("led_mirror", 32'($sampled(exp_led)), 32'($sampled(led)));

    // ------------------------------
    // Clock and stimulus
    // ------------------------------

    initial begin
        slow_clk = 1'b0;
        forever #10 slow_clk = ~slow_clk;
    end

    initial begin
        rst      = 1'b1;
        key      = 2'b00;
        drained  = 1'b0;
        lfsr     = 32'h4428_b902;
        up_key   = 1'b0;
        down_key = 1'b0;
        wait_cnt = 0;
        repeat (8) @(posedge slow_clk);
        rst <= 1'b0;

        // Idle cycles so the post reset state is seen
        repeat (3) @(posedge slow_clk);

        // Free random phase
        repeat (400) begin
            @(posedge slow_clk);
            lfsr     = lfsr_next(lfsr);
            up_key   = lfsr[0];
            lfsr     = lfsr_next(lfsr);
            down_key = lfsr[0];
            key <= {up_key, down_key};
        end

        // Back-pressure, offer operands with nobody taking results
        @(posedge slow_clk);
        key <= 2'b10;
        repeat (20) @(posedge slow_clk);

        // Drain until the FIFO reports empty
        key <= 2'b01;
        wait_cnt = 0;
        while (down_vld) begin
            @(posedge slow_clk);
            wait_cnt++;
            if (wait_cnt > drain_timeout) begin
                report_failure("timeout waiting for the drain to finish");
            end
        end
        drained <= 1'b1;
        repeat (10) @(posedge slow_clk);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
design/pow5_pkg.sv
design/display_pkg.sv
design/display_feed_if.sv
design/operand_counter.sv
design/pow5_pipeline.sv
design/result_fifo.sv
design/pow5_credit_unit.sv
design/segment_scanner.sv
design/pow5_board_top.sv
testbench/tb_pow5_board.sv

// ==== Makefile ====
# Verilator build for the fifth power pipeline board project

VERILATOR  ?= verilator
FILELIST   := files.f
TB_TOP     := tb_pow5_board
RTL_TOP    := pow5_board_top
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TB_TOP)

clean:
	rm -rf $(OBJ_DIR)
